// File: Makefile
.PHONY: run clean

obj_dir/Vcpu_tb: cpu.f source/*.sv tb/cpu_tb.sv tb/cpu_model.svh
	verilator --binary --timing --assert --top-module cpu_tb -f cpu.f

run: obj_dir/Vcpu_tb
	@out="$$(./obj_dir/Vcpu_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: cpu.f
+incdir+tb
source/rv32i_types.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/register_file.sv
source/cpu.sv
tb/cpu_tb.sv

// File: source/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter rv32i_types::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,

    output rv32i_types::word_t   imem_addr,
    output rv32i_types::mask_t   imem_rmask,
    input  rv32i_types::word_t   imem_rdata,
    input  logic                 imem_resp,

    output rv32i_types::word_t   dmem_addr,
    output rv32i_types::mask_t   dmem_rmask,
    output rv32i_types::mask_t   dmem_wmask,
    input  rv32i_types::word_t   dmem_rdata,
    output rv32i_types::word_t   dmem_wdata,
    input  logic                 dmem_resp
);

    rv32i_types::if_id_t    if_id_reg, if_id_next;
    rv32i_types::id_ex_t    id_ex_reg, id_ex_next;
    rv32i_types::ex_mem_t   ex_mem_reg, ex_mem_next;
    rv32i_types::mem_wb_t   mem_wb_reg, mem_wb_next;

    rv32i_types::reg_sel_t  rs1_s, rs2_s;
    rv32i_types::word_t     rs1_v, rs2_v;
    logic                   mem_busy;
    logic                   stall_id;
    logic                   fetch_stall;

    assign fetch_stall = mem_busy || stall_id;

    // mem_busy freezes everything, stall_id bubbles into execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id_reg.valid  <= 1'b0;
            id_ex_reg.valid  <= 1'b0;
            ex_mem_reg.valid <= 1'b0;
            mem_wb_reg.valid <= 1'b0;
        end else if (!mem_busy) begin
            if (!stall_id) begin
                if_id_reg <= if_id_next;
            end
            id_ex_reg <= id_ex_next;
            if (stall_id) begin
                id_ex_reg.valid <= 1'b0;
            end
            ex_mem_reg <= ex_mem_next;
            mem_wb_reg <= mem_wb_next;
        end
    end

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (fetch_stall),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .if_id      (if_id_next)
    );

    decode_stage i_decode (
        .if_id      (if_id_reg),
        .rs1_v      (rs1_v),
        .rs2_v      (rs2_v),
        .ex_rd      (id_ex_reg.rd),
        .mem_rd     (ex_mem_reg.rd),
        .wb_rd      (mem_wb_reg.rd),
        .ex_writes  (id_ex_reg.valid && id_ex_reg.reg_write),
        .mem_writes (ex_mem_reg.valid && ex_mem_reg.reg_write),
        .wb_writes  (mem_wb_reg.valid && mem_wb_reg.reg_write),
        .rs1_s      (rs1_s),
        .rs2_s      (rs2_s),
        .stall_id   (stall_id),
        .id_ex      (id_ex_next)
    );

    execute_stage i_execute (
        .id_ex  (id_ex_reg),
        .ex_mem (ex_mem_next)
    );

    memory_stage i_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem_reg),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .mem_busy   (mem_busy),
        .mem_wb     (mem_wb_next)
    );

    register_file i_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .mem_wb (mem_wb_reg),
        .rs1_s  (rs1_s),
        .rs2_s  (rs2_s),
        .rs1_v  (rs1_v),
        .rs2_v  (rs2_v)
    );

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  rv32i_types::if_id_t    if_id,
    input  rv32i_types::word_t     rs1_v,
    input  rv32i_types::word_t     rs2_v,
    input  rv32i_types::reg_sel_t  ex_rd,
    input  rv32i_types::reg_sel_t  mem_rd,
    input  rv32i_types::reg_sel_t  wb_rd,
    input  logic                   ex_writes,
    input  logic                   mem_writes,
    input  logic                   wb_writes,
    output rv32i_types::reg_sel_t  rs1_s,
    output rv32i_types::reg_sel_t  rs2_s,
    output logic                   stall_id,
    output rv32i_types::id_ex_t    id_ex
);

    rv32i_types::word_t    instr;
    rv32i_types::word_t    imm_i, imm_s, imm_u;
    rv32i_types::alu_op_e  f3_op;
    logic                  f3_known;
    logic                  use_rs1, use_rs2;
    logic                  rs1_hit, rs2_hit;
    logic [2:0]            funct3;
    logic [6:0]            funct7;

    assign instr  = if_id.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1_s  = instr[19:15];
    assign rs2_s  = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'h000};

    // ALU operation shared by OP and OP-IMM
    always_comb begin
        f3_known = 1'b1;
        f3_op    = rv32i_types::alu_add;
        case (funct3)
            3'b000:  f3_op = rv32i_types::alu_add;
            3'b010:  f3_op = rv32i_types::alu_slt;
            3'b100:  f3_op = rv32i_types::alu_xor;
            3'b110:  f3_op = rv32i_types::alu_or;
            3'b111:  f3_op = rv32i_types::alu_and;
            default: f3_known = 1'b0;
        endcase
    end

    always_comb begin
        id_ex            = '0;
        id_ex.valid      = if_id.valid;
        id_ex.alu_op     = rv32i_types::alu_add;
        id_ex.a          = rs1_v;
        id_ex.b          = rs2_v;
        id_ex.store_data = rs2_v;
        id_ex.rd         = instr[11:7];
        use_rs1          = 1'b0;
        use_rs2          = 1'b0;
        case (rv32i_types::opcode_e'(instr[6:0]))
            rv32i_types::op_lui: begin
                id_ex.alu_op    = rv32i_types::alu_pass_b;
                id_ex.b         = imm_u;
                id_ex.reg_write = 1'b1;
            end
            rv32i_types::op_imm: if (f3_known) begin
                id_ex.alu_op    = f3_op;
                id_ex.b         = imm_i;
                id_ex.reg_write = 1'b1;
                use_rs1         = 1'b1;
            end
            rv32i_types::op_reg:
                if (f3_known && (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000))) begin
                    id_ex.alu_op    = funct7[5] ? rv32i_types::alu_sub : f3_op;
                    id_ex.reg_write = 1'b1;
                    use_rs1         = 1'b1;
                    use_rs2         = 1'b1;
                end
            rv32i_types::op_load: if (funct3 == 3'b010) begin
                id_ex.b         = imm_i;
                id_ex.reg_write = 1'b1;
                id_ex.mem_read  = 1'b1;
                use_rs1         = 1'b1;
            end
            rv32i_types::op_store: if (funct3 == 3'b010) begin
                id_ex.b         = imm_s;
                id_ex.mem_write = 1'b1;
                use_rs1         = 1'b1;
                use_rs2         = 1'b1;
            end
            default: ;
        endcase
    end

    // No forwarding, so wait until the producer has left writeback
    assign rs1_hit = use_rs1 && (rs1_s != '0) &&
                     ((ex_writes && ex_rd == rs1_s) || (mem_writes && mem_rd == rs1_s) ||
                      (wb_writes && wb_rd == rs1_s));
    assign rs2_hit = use_rs2 && (rs2_s != '0) &&
                     ((ex_writes && ex_rd == rs2_s) || (mem_writes && mem_rd == rs2_s) ||
                      (wb_writes && wb_rd == rs2_s));
    assign stall_id = if_id.valid && (rs1_hit || rs2_hit);

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  rv32i_types::id_ex_t   id_ex,
    output rv32i_types::ex_mem_t  ex_mem
);

    rv32i_types::word_t result;
    logic               less;

    // SLT compares as signed values
    assign less = $signed(id_ex.a) < $signed(id_ex.b);

    always_comb begin
        case (id_ex.alu_op)
            rv32i_types::alu_add: begin
                result = id_ex.a + id_ex.b;
            end
            rv32i_types::alu_sub: begin
                result = id_ex.a - id_ex.b;
            end
            rv32i_types::alu_and: begin
                result = id_ex.a & id_ex.b;
            end
            rv32i_types::alu_or: begin
                result = id_ex.a | id_ex.b;
            end
            rv32i_types::alu_xor: begin
                result = id_ex.a ^ id_ex.b;
            end
            rv32i_types::alu_slt: begin
                result = {31'b0, less};
            end
            rv32i_types::alu_pass_b: begin
                result = id_ex.b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Loads and stores use the add result as their address
    always_comb begin
        ex_mem.valid      = id_ex.valid;
        ex_mem.alu_result = result;
        ex_mem.store_data = id_ex.store_data;
        ex_mem.rd         = id_ex.rd;
        ex_mem.reg_write  = id_ex.reg_write;
        ex_mem.mem_read   = id_ex.mem_read;
        ex_mem.mem_write  = id_ex.mem_write;
    end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv32i_types::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  rv32i_types::word_t   imem_rdata,
    input  logic                 imem_resp,
    output rv32i_types::word_t   imem_addr,
    output rv32i_types::mask_t   imem_rmask,
    output rv32i_types::if_id_t  if_id
);

    typedef enum logic {req, hold} fetch_state_e;

    fetch_state_e       state;
    rv32i_types::word_t pc;
    rv32i_types::word_t held_instr;

    assign imem_addr  = pc;
    assign imem_rmask = (state == req) ? 4'hf : 4'h0;

    // A response taken during a stall waits in held_instr
    assign if_id.valid = (state == hold) || imem_resp;
    assign if_id.pc    = pc;
    assign if_id.instr = (state == hold) ? held_instr : imem_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= req;
            pc    <= RESET_PC;
        end else begin
            if (if_id.valid && !stall) begin
                pc <= pc + 32'd4;
            end
            case (state)
                req:     if (imem_resp && stall) state <= hold;
                hold:    if (!stall) state <= req;
                default: state <= req;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == req && imem_resp && stall) begin
            held_instr <= imem_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        ((|imem_rmask) && !imem_resp) |=> $stable(imem_addr))
        else $error("imem_addr changed while a fetch was outstanding");

endmodule

// File: source/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_types::ex_mem_t   ex_mem,
    input  rv32i_types::word_t     dmem_rdata,
    input  logic                   dmem_resp,
    output rv32i_types::word_t     dmem_addr,
    output rv32i_types::word_t     dmem_wdata,
    output rv32i_types::mask_t     dmem_rmask,
    output rv32i_types::mask_t     dmem_wmask,
    output logic                   mem_busy,
    output rv32i_types::mem_wb_t   mem_wb
);

    typedef enum logic {idle, wait_resp} mem_state_e;

    mem_state_e state;
    logic       access;
    logic       done;

    assign access = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    // The response finishes the access and lets the pipeline move on
    assign done     = (state == wait_resp) && dmem_resp;
    assign mem_busy = access && !done;

    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_rmask = (access && ex_mem.mem_read) ? 4'hf : 4'h0;
    assign dmem_wmask = (access && ex_mem.mem_write) ? 4'hf : 4'h0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle:      if (access) state <= wait_resp;
                wait_resp: if (done) state <= idle;
                default:   state <= idle;
            endcase
        end
    end

    always_comb begin
        mem_wb.valid     = ex_mem.valid;
        mem_wb.rd        = ex_mem.rd;
        mem_wb.reg_write = ex_mem.reg_write;
        mem_wb.value     = ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !((|dmem_rmask) && (|dmem_wmask)))
        else $error("dmem read and write requested together");

    // A response is only expected after a request was issued
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == idle) |-> !dmem_resp)
        else $error("dmem_resp without an outstanding request");

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_types::mem_wb_t   mem_wb,
    input  rv32i_types::reg_sel_t  rs1_s,
    input  rv32i_types::reg_sel_t  rs2_s,
    output rv32i_types::word_t     rs1_v,
    output rv32i_types::word_t     rs2_v
);

    // x0 has no storage
    rv32i_types::word_t regs [1:31];
    logic               we;

    assign we = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[mem_wb.rd] <= mem_wb.value;
        end
    end

    // Reads see the old value during the write cycle
    always_comb begin
        if (rs1_s == '0) begin
            rs1_v = '0;
        end else begin
            rs1_v = regs[rs1_s];
        end
    end

    always_comb begin
        if (rs2_s == '0) begin
            rs2_v = '0;
        end else begin
            rs2_v = regs[rs2_s];
        end
    end

endmodule

// File: source/rv32i_types.sv
package rv32i_types;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_sel_t;
    typedef logic [3:0]  mask_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        word_t    a;
        word_t    b;
        word_t    store_data;
        reg_sel_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    store_data;
        reg_sel_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_sel_t rd;
        logic     reg_write;
        word_t    value;
    } mem_wb_t;

endpackage

// File: tb/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam logic [31:0] NOP_INSTR = 32'h0000_0013;
localparam logic [11:0] DATA_BASE = 12'h400;
localparam logic [11:0] DUMP_BASE = 12'h600;
localparam int          BODY_LEN  = 200;

logic [31:0] lfsr_state = 32'd98213;
logic [31:0] prog [0:511];
int          prog_len;
logic [31:0] model_regs [0:31];
logic [31:0] model_mem [0:1023];
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];

// Fibonacci LFSR with taps 32, 22, 2, 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r = {r[30:0], fb};
    end
    return r;
endfunction

function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = rand_bits(5);
    return r[4:0];
endfunction

function automatic logic [2:0] rand_funct3();
    logic [31:0] r;
    r = rand_bits(3);
    case (r[2:0])
        3'd0, 3'd5: return 3'b000;
        3'd1, 3'd6: return 3'b010;
        3'd2:       return 3'b100;
        3'd3:       return 3'b110;
        default:    return 3'b111;
    endcase
endfunction

// Initial data memory contents, built from the full byte address
function automatic logic [31:0] init_word(input int k);
    logic [31:0] a;
    a = 32'(k) << 2;
    return {a[15:0], ~a[15:0]};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic void gen_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] off;
    int          n;
    n = 0;
    // Seed every register with an LUI/ADDI pair
    for (int i = 1; i < 32; i++) begin
        r = rand_bits(20);
        prog[n] = {r[19:0], 5'(i), 7'b0110111};
        n++;
        r = rand_bits(12);
        prog[n] = enc_i(r[11:0], 5'(i), 3'b000, 5'(i), 7'b0010011);
        n++;
    end
    for (int i = 0; i < BODY_LEN; i++) begin
        rd  = rand_reg();
        rs1 = rand_reg();
        rs2 = rand_reg();
        r   = rand_bits(6);
        off = DATA_BASE + {4'b0, r[5:0], 2'b00};
        r   = rand_bits(3);
        case (r[2:0])
            3'd0, 3'd1: begin
                f3 = rand_funct3();
                r  = rand_bits(12);
                prog[n] = enc_i(r[11:0], rs1, f3, rd, 7'b0010011);
            end
            3'd2, 3'd3: begin
                f3 = rand_funct3();
                r  = rand_bits(1);
                f7 = (f3 == 3'b000 && r[0]) ? 7'h20 : 7'h00;
                prog[n] = enc_r(f7, rs2, rs1, f3, rd);
            end
            3'd4: begin
                r = rand_bits(20);
                prog[n] = {r[19:0], rd, 7'b0110111};
            end
            3'd5: begin
                prog[n] = enc_i(off, 5'd0, 3'b010, rd, 7'b0000011);
            end
            3'd6: begin
                prog[n] = enc_s(off, rs2);
            end
            default: begin
                // Load immediately followed by a use of its result
                prog[n] = enc_i(off, 5'd0, 3'b010, rd, 7'b0000011);
                n++;
                prog[n] = enc_r(7'h00, rs2, rd, 3'b000, rs1);
            end
        endcase
        n++;
    end
    for (int k = 0; k < 32; k++) begin
        prog[n] = enc_s(DUMP_BASE + {5'b0, 5'(k), 2'b00}, 5'(k));
        n++;
    end
    prog_len = n;
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b, input logic sub);
    case (f3)
        3'b000:  return sub ? a - b : a + b;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return 32'd0;
    endcase
endfunction

// Sequential reference execution of the whole program
function automatic void run_model();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] ad;
    logic        wr;
    for (int k = 0; k < 1024; k++) begin
        model_mem[k] = init_word(k);
    end
    for (int k = 0; k < 32; k++) begin
        model_regs[k] = 32'd0;
    end
    for (int p = 0; p < prog_len; p++) begin
        ins = prog[p];
        a   = model_regs[ins[19:15]];
        b   = model_regs[ins[24:20]];
        res = 32'd0;
        wr  = 1'b1;
        case (ins[6:0])
            7'b0110111: res = {ins[31:12], 12'h000};
            7'b0010011: res = alu_ref(ins[14:12], a, {{20{ins[31]}}, ins[31:20]}, 1'b0);
            7'b0110011: res = alu_ref(ins[14:12], a, b, ins[30]);
            7'b0000011: begin
                ad  = a + {{20{ins[31]}}, ins[31:20]};
                res = model_mem[ad[11:2]];
            end
            default: begin
                wr = 1'b0;
                ad = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                exp_addr.push_back(ad);
                exp_data.push_back(b);
                model_mem[ad[11:2]] = b;
            end
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = res;
        end
    end
endfunction

`endif

// File: tb/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam int          DUMP_IDX = 384;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] imem_rdata = 32'd0;
    logic        imem_resp = 1'b0;
    logic [31:0] dmem_rdata = 32'd0;
    logic        dmem_resp = 1'b0;
    logic [31:0] imem_addr;
    logic [3:0]  imem_rmask;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_rmask;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_wdata;

    logic [31:0] dmem [0:1023];
    logic        gen_done = 1'b0;
    logic        i_busy = 1'b0;
    logic        d_busy = 1'b0;
    logic [2:0]  i_wait = 3'd0;
    logic [2:0]  d_wait = 3'd0;
    int          wr_count = 0;
    int          seq_errors = 0;
    int          reset_errors = 0;
    int          exp_count;
    int          passed = 0;
    int          failed = 0;

    `include "cpu_model.svh"

    cpu #(
        .RESET_PC (RESET_PC)
    ) i_cpu (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_resp  (dmem_resp)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr[1:0] != 2'b00 || idx >= 32'(prog_len)) begin
            return NOP_INSTR;
        end
        return prog[idx[8:0]];
    endfunction

    // Compares one write request with the next store of the model
    task automatic check_store();
        if (wr_count >= exp_addr.size()) begin
            $display("Unexpected extra store to %08h beyond the %0d stores",
                     dmem_addr, exp_addr.size());
            seq_errors++;
        end else if (dmem_addr != exp_addr[wr_count] ||
                     dmem_wdata != exp_data[wr_count]) begin
            $display(
                "[ERROR] store_sequence: store %0d expected %08h <= %08h, actual %08h <= %08h",
                wr_count, exp_addr[wr_count], exp_data[wr_count], dmem_addr, dmem_wdata);
            seq_errors++;
        end
    endtask

    // Both memories answer 1 to 4 cycles after a request
    always @(negedge clk) begin
        logic [31:0] r;
        imem_resp = 1'b0;
        dmem_resp = 1'b0;
        if (!rst_n) begin
            for (int k = 0; k < 1024; k++) begin
                dmem[k] = init_word(k);
            end
        end else begin
            if (!i_busy && imem_rmask != 4'h0) begin
                r = rand_bits(2);
                i_busy = 1'b1;
                i_wait = {1'b0, r[1:0]} + 3'd1;
            end
            if (i_busy) begin
                if (i_wait == 3'd0) begin
                    imem_resp = 1'b1;
                    imem_rdata = fetch_word(imem_addr);
                    i_busy = 1'b0;
                end else begin
                    i_wait = i_wait - 3'd1;
                end
            end
            if (!d_busy && (dmem_rmask != 4'h0 || dmem_wmask != 4'h0)) begin
                r = rand_bits(2);
                d_busy = 1'b1;
                d_wait = {1'b0, r[1:0]} + 3'd1;
            end
            if (d_busy) begin
                if (d_wait == 3'd0) begin
                    dmem_resp = 1'b1;
                    d_busy = 1'b0;
                    if (dmem_wmask != 4'h0) begin
                        check_store();
                        dmem[dmem_addr[11:2]] = dmem_wdata;
                        wr_count++;
                    end else begin
                        dmem_rdata = dmem[dmem_addr[11:2]];
                    end
                end else begin
                    d_wait = d_wait - 3'd1;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n && (dmem_rmask != 4'h0 || dmem_wmask != 4'h0)) begin
            reset_errors++;
        end
    end

    initial begin
        wait (gen_done);
        #(prog_len * 4 * 8 * 20);
        $display("Timeout: only %0d of %0d stores seen before the time limit",
                 wr_count, exp_count);
        $display("Test failed");
        $finish;
    end

    task automatic report(input string name, input int errors);
        if (errors == 0) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: FAIL (%0d errors)", name, errors);
            failed++;
        end
    endtask

    initial begin
        int errs;
        gen_program();
        run_model();
        exp_count = exp_addr.size();
        gen_done = 1'b1;
        repeat (5) @(negedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        errs = reset_errors;
        if (imem_addr != RESET_PC || imem_rmask != 4'hf) begin
            $display("[ERROR] reset_fetch: expected %08h/f, actual %08h/%h",
                     RESET_PC, imem_addr, imem_rmask);
            errs++;
        end
        if (reset_errors != 0) begin
            $display("Data mask was nonzero during reset");
        end
        report("reset_fetch", errs);

        wait (wr_count == exp_count);
        // Extra cycles let a duplicated store show up
        repeat (40) @(negedge clk);
        report("store_sequence", seq_errors);

        errs = 0;
        if (wr_count != exp_count) begin
            $display("[ERROR] store_count: expected %0d, actual %0d", exp_count, wr_count);
            errs++;
        end
        report("store_count", errs);

        errs = 0;
        for (int k = 0; k < 32; k++) begin
            if (dmem[DUMP_IDX + k] != model_regs[k]) begin
                $display("[ERROR] register_dump: x%0d expected %08h, actual %08h",
                         k, model_regs[k], dmem[DUMP_IDX + k]);
                errs++;
            end
        end
        report("register_dump", errs);

        errs = 0;
        for (int k = 0; k < 1024; k++) begin
            if (dmem[k] != model_mem[k]) begin
                $display("[ERROR] data_memory: word %08h expected %08h, actual %08h",
                         k * 4, model_mem[k], dmem[k]);
                errs++;
            end
        end
        report("data_memory", errs);

        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
